//--- run_sim.sh
#!/bin/sh
# build and run the mem_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module mem_stage_tb -f tb.f -o mem_stage_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/mem_stage_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

# the testbench prints the fail message on any failure
if grep -q "Something failed" "$LOG"; then
	exit 1
fi
exit 0

//--- src/cp0_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regfile (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire [5:0] ext_int,
	input wire mem_pkg::cp0_op_t cp0_op,
	input wire mem_pkg::exc_code_t exc_code,
	input wire bd,
	input wire [31:0] exc_epc,
	input wire [31:0] badvaddr,
	input wire [4:0] addr,
	input wire [2:0] sel,
	input wire [31:0] wdata,
	output logic [31:0] rdata,
	output logic [31:0] status,
	output logic [31:0] cause,
	output logic [31:0] epc
);
	import mem_pkg::*;

	logic [31:0] badvaddr_reg;
	logic [31:0] count_reg;
	logic tick;
	logic mtc0_wr;
	logic exc_wr;
	logic eret_wr;
	logic addr_exc;

	// a stalled instruction must not touch cp0
	assign mtc0_wr = (cp0_op == CP0_MTC0) && (sel == 3'd0) && !stall;
	assign exc_wr = (cp0_op == CP0_EXC) && !stall;
	assign eret_wr = (cp0_op == CP0_ERET) && !stall;
	assign addr_exc = (exc_code == EXC_ADEL) || (exc_code == EXC_ADES);

	// count runs at half the clock, even while stalled
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tick <= 1'b0;
			count_reg <= '0;
		end else begin
			tick <= ~tick;
			if (mtc0_wr && addr == CP0_COUNT)
				count_reg <= wdata;
			else if (tick)
				count_reg <= count_reg + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			status <= STATUS_RESET;
		end else if (exc_wr) begin
			status[STATUS_EXL] <= 1'b1;
		end else if (eret_wr) begin
			status[STATUS_EXL] <= 1'b0;
		end else if (mtc0_wr && addr == CP0_STATUS) begin
			status <= (status & ~STATUS_WMASK) | (wdata & STATUS_WMASK);
		end
	end

	// hardware interrupt lines land in IP7..2
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cause <= '0;
		end else begin
			cause[15:10] <= ext_int;
			if (exc_wr) begin
				cause[CAUSE_BD] <= bd;
				cause[6:2] <= exc_code;
			end else if (mtc0_wr && addr == CP0_CAUSE) begin
				cause[9:8] <= wdata[9:8];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			epc <= '0;
			badvaddr_reg <= '0;
		end else begin
			if (exc_wr)
				epc <= exc_epc;
			else if (mtc0_wr && addr == CP0_EPC)
				epc <= wdata;
			// only address errors report a bad address
			if (exc_wr && addr_exc)
				badvaddr_reg <= badvaddr;
		end
	end

	// unimplemented registers and selects read zero
	always_comb begin
		rdata = '0;
		if (sel == 3'd0) begin
			case (addr)
				CP0_BADVADDR: rdata = badvaddr_reg;
				CP0_COUNT: rdata = count_reg;
				CP0_STATUS: rdata = status;
				CP0_CAUSE: rdata = cause;
				CP0_EPC: rdata = epc;
				default: rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/data_addr_check.sv
`timescale 1ns/1ps
`default_nettype none

module data_addr_check (
	input wire mem_req,
	input wire mem_wr,
	input wire mem_pkg::mem_size_t mem_size,
	input wire [31:0] addr,
	input wire addr_err_if,
	input wire [31:0] pc,
	input wire kill,
	output logic [31:0] badvaddr,
	output logic [1:0] addr_err,
	output logic data_req
);
	import mem_pkg::*;

	logic misaligned;

	// halfwords need bit 0 clear, words need both low bits clear
	always_comb begin
		case (mem_size)
			SIZE_HALF: misaligned = addr[0];
			SIZE_WORD: misaligned = |addr[1:0];
			default: misaligned = 1'b0;
		endcase
	end

	// bit 0 load error, bit 1 store error
	assign addr_err[0] = mem_req & ~mem_wr & misaligned;
	assign addr_err[1] = mem_req & mem_wr & misaligned;

	// a fetch error reports the pc instead of the data address
	assign badvaddr = addr_err_if ? pc : addr;

	assign data_req = mem_req & ~misaligned & ~kill;

endmodule

`default_nettype wire

//--- src/exc_handler.sv
`timescale 1ns/1ps
`default_nettype none

module exc_handler #(
	parameter logic [31:0] EXC_VECTOR = 32'hBFC0_0380
) (
	input wire is_instr,
	input wire in_delay_slot,
	input wire [31:0] pc,
	input wire [31:0] badvaddr_in,
	input wire [1:0] addr_err,
	input wire addr_err_if,
	input wire reserved_instr,
	input wire int_ovf,
	input wire syscall,
	input wire brk,
	input wire eret,
	input wire mtc0,
	input wire [31:0] status,
	input wire [31:0] cause,
	input wire [31:0] epc,
	output mem_pkg::cp0_op_t cp0_op,
	output mem_pkg::exc_code_t exc_code,
	output logic bd,
	output logic [31:0] exc_epc,
	output logic kill,
	output logic exc_flush,
	output logic [31:0] exc_target
);
	import mem_pkg::*;

	logic int_pending;
	logic data_err;
	logic take_exc;

	// IE set, EXL clear, some enabled IP bit high
	assign int_pending = status[STATUS_IE] & ~status[STATUS_EXL] &
		(|(cause[15:8] & status[15:8]));

	assign data_err = |addr_err;

	// highest priority first
	always_comb begin
		take_exc = 1'b1;
		exc_code = EXC_INT;
		if (int_pending && is_instr)
			exc_code = EXC_INT;
		else if (addr_err_if)
			exc_code = EXC_ADEL;
		else if (reserved_instr)
			exc_code = EXC_RI;
		else if (int_ovf)
			exc_code = EXC_OV;
		else if (syscall)
			exc_code = EXC_SYS;
		else if (brk)
			exc_code = EXC_BP;
		else if (data_err)
			exc_code = addr_err[0] ? EXC_ADEL : EXC_ADES;
		else
			take_exc = 1'b0;
	end

	always_comb begin
		if (take_exc)
			cp0_op = CP0_EXC;
		else if (eret)
			cp0_op = CP0_ERET;
		else if (mtc0)
			cp0_op = CP0_MTC0;
		else
			cp0_op = CP0_NONE;
	end

	// restart at the branch when the victim sits in a delay slot
	assign bd = in_delay_slot;
	assign exc_epc = in_delay_slot ? pc - 32'd4 : pc;

	assign kill = take_exc;
	assign exc_flush = take_exc | eret;
	assign exc_target = take_exc ? EXC_VECTOR : epc;

endmodule

`default_nettype wire

//--- src/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// what coprocessor 0 does this cycle
	typedef enum logic [1:0] {
		CP0_NONE = 2'd0,
		CP0_MTC0 = 2'd1,
		CP0_EXC  = 2'd2,
		CP0_ERET = 2'd3
	} cp0_op_t;

	// cause ExcCode field values
	typedef enum logic [4:0] {
		EXC_INT  = 5'd0,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_RI   = 5'd10,
		EXC_OV   = 5'd12
	} exc_code_t;

	// access size, same encoding as the data port
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_t;

	// implemented cp0 register numbers, all at select 0
	localparam logic [4:0] CP0_BADVADDR = 5'd8;
	localparam logic [4:0] CP0_COUNT    = 5'd9;
	localparam logic [4:0] CP0_STATUS   = 5'd12;
	localparam logic [4:0] CP0_CAUSE    = 5'd13;
	localparam logic [4:0] CP0_EPC      = 5'd14;

	// status fields
	localparam int STATUS_IE  = 0;
	localparam int STATUS_EXL = 1;
	localparam int STATUS_BEV = 22;
	// only IM, EXL and IE are software writable
	localparam logic [31:0] STATUS_WMASK = 32'h0000_FF03;

	// BEV set, everything else clear
	localparam logic [31:0] STATUS_RESET = 32'h0040_0000;

	// cause fields
	localparam int CAUSE_BD = 31;

endpackage

`default_nettype wire

//--- src/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
	parameter logic [31:0] EXC_VECTOR = 32'hBFC0_0380
) (
	input wire clk,
	input wire rst_n,
	input wire [5:0] ext_int,
	input wire stall,
	input wire is_instr,
	input wire in_delay_slot,
	input wire [31:0] pc,
	input wire [31:0] alu_out,
	input wire [31:0] rt_data,
	input wire [4:0] rd,
	input wire [2:0] cp0_sel,
	input wire mem_req,
	input wire mem_wr,
	input wire mem_pkg::mem_size_t mem_size,
	input wire addr_err_if,
	input wire reserved_instr,
	input wire int_ovf,
	input wire syscall,
	input wire brk,
	input wire eret,
	input wire mtc0,
	output logic data_req,
	output logic data_wr,
	output mem_pkg::mem_size_t data_size,
	output logic [31:0] data_addr,
	output logic [31:0] data_wdata,
	output logic [3:0] data_wstrb,
	output logic [31:0] cp0_rdata,
	output logic exc_flush,
	output logic [31:0] exc_target
);
	import mem_pkg::*;

	logic [31:0] badvaddr;
	logic [1:0] addr_err;
	logic kill;
	cp0_op_t cp0_op;
	exc_code_t exc_code;
	logic bd;
	logic [31:0] exc_epc;
	logic [31:0] cp0_status;
	logic [31:0] cp0_cause;
	logic [31:0] cp0_epc;

	// the alu result is the data address
	assign data_wr = mem_wr;
	assign data_size = mem_size;
	assign data_addr = alu_out;

	data_addr_check data_addr_check_i (
		.mem_req(mem_req),
		.mem_wr(mem_wr),
		.mem_size(mem_size),
		.addr(alu_out),
		.addr_err_if(addr_err_if),
		.pc(pc),
		.kill(kill),
		.badvaddr(badvaddr),
		.addr_err(addr_err),
		.data_req(data_req)
	);

	store_data_align store_data_align_i (
		.mem_size(mem_size),
		.offset(alu_out[1:0]),
		.wr(mem_wr),
		.req(data_req),
		.wdata_in(rt_data),
		.wdata(data_wdata),
		.wstrb(data_wstrb)
	);

	exc_handler #(
		.EXC_VECTOR(EXC_VECTOR)
	) exc_handler_i (
		.is_instr(is_instr),
		.in_delay_slot(in_delay_slot),
		.pc(pc),
		.badvaddr_in(badvaddr),
		.addr_err(addr_err),
		.addr_err_if(addr_err_if),
		.reserved_instr(reserved_instr),
		.int_ovf(int_ovf),
		.syscall(syscall),
		.brk(brk),
		.eret(eret),
		.mtc0(mtc0),
		.status(cp0_status),
		.cause(cp0_cause),
		.epc(cp0_epc),
		.cp0_op(cp0_op),
		.exc_code(exc_code),
		.bd(bd),
		.exc_epc(exc_epc),
		.kill(kill),
		.exc_flush(exc_flush),
		.exc_target(exc_target)
	);

	// mtc0 writes rt into the register named by rd
	cp0_regfile cp0_regfile_i (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.ext_int(ext_int),
		.cp0_op(cp0_op),
		.exc_code(exc_code),
		.bd(bd),
		.exc_epc(exc_epc),
		.badvaddr(badvaddr),
		.addr(rd),
		.sel(cp0_sel),
		.wdata(rt_data),
		.rdata(cp0_rdata),
		.status(cp0_status),
		.cause(cp0_cause),
		.epc(cp0_epc)
	);

endmodule

`default_nettype wire

//--- src/store_data_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_data_align (
	input wire mem_pkg::mem_size_t mem_size,
	input wire [1:0] offset,
	input wire wr,
	input wire req,
	input wire [31:0] wdata_in,
	output logic [31:0] wdata,
	output logic [3:0] wstrb
);
	import mem_pkg::*;

	logic [3:0] lanes;

	// replicate so the memory can pick any lane
	always_comb begin
		case (mem_size)
			SIZE_BYTE: begin
				wdata = {4{wdata_in[7:0]}};
				lanes = 4'b0001 << offset;
			end
			SIZE_HALF: begin
				wdata = {2{wdata_in[15:0]}};
				lanes = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				wdata = wdata_in;
				lanes = 4'b1111;
			end
		endcase
	end

	// strobes only for a store that actually goes out
	assign wstrb = (req && wr) ? lanes : 4'b0000;

endmodule

`default_nettype wire

//--- tb.f
src/mem_pkg.sv
src/data_addr_check.sv
src/store_data_align.sv
src/exc_handler.sv
src/cp0_regfile.sv
src/mem_stage.sv
verification/mem_stage_tb.sv

//--- verification/mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;
	import mem_pkg::*;

	localparam logic [31:0] VECTOR = 32'hBFC0_0380;
	localparam int NUM_INSTR = 2000;
	localparam int CYCLE_LIMIT = 10 + NUM_INSTR + 200;

	logic clk = 1'b0;
	logic rst_n;
	logic [5:0] ext_int;
	logic stall, is_instr, in_delay_slot;
	logic [31:0] pc, alu_out, rt_data;
	logic [4:0] rd;
	logic [2:0] cp0_sel;
	logic mem_req, mem_wr;
	mem_size_t mem_size;
	logic addr_err_if, reserved_instr, int_ovf, syscall, brk, eret, mtc0;

	logic data_req, data_wr, exc_flush;
	mem_size_t data_size;
	logic [31:0] data_addr, data_wdata, cp0_rdata, exc_target;
	logic [3:0] data_wstrb;

	// reference copy of cp0
	logic [31:0] m_status, m_cause, m_epc, m_badvaddr, m_count;
	logic m_tick;
	// exception decision of the current cycle, used at the next edge
	logic exp_take;
	exc_code_t exp_code;

	logic [31:0] rng = 32'h8bb7_8a80;
	int word_errs = 0;
	int flag_errs = 0;
	int strb_errs = 0;
	int size_errs = 0;
	int cycle_count = 0;

	mem_stage #(
		.EXC_VECTOR(VECTOR)
	) mem_stage_i (.*);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			word_errs++;
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			flag_errs++;
			$display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_strb(input string name, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) begin
			strb_errs++;
			$display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_size(input string name, input mem_size_t exp, input mem_size_t act);
		if (act !== exp) begin
			size_errs++;
			$display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic drive_random();
		logic [31:0] s;
		logic [31:0] r;
		logic [31:0] f;
		logic [31:0] v;
		next_rand(s);
		next_rand(r);
		next_rand(f);
		stall <= (s % 32'd10) == 32'd0;
		// interrupt lines move now and then
		if (s[31:28] == 4'd0)
			ext_int <= s[27:22];
		case ((s >> 4) % 32'd3)
			32'd0: mem_size <= SIZE_BYTE;
			32'd1: mem_size <= SIZE_HALF;
			default: mem_size <= SIZE_WORD;
		endcase
		is_instr <= r[2:0] != 3'd0;
		in_delay_slot <= r[4:3] == 2'd0;
		mem_req <= r[5];
		mem_wr <= r[6];
		case (r[9:7])
			3'd0: rd <= CP0_BADVADDR;
			3'd1: rd <= CP0_COUNT;
			3'd2, 3'd6: rd <= CP0_STATUS;
			3'd3, 3'd4: rd <= CP0_CAUSE;
			3'd5: rd <= CP0_EPC;
			default: rd <= r[14:10];
		endcase
		cp0_sel <= (r[17:15] == 3'd0) ? r[20:18] : 3'd0;
		// exception flags stay rare
		addr_err_if <= f[4:0] == 5'd0;
		reserved_instr <= f[9:5] == 5'd0;
		int_ovf <= f[14:10] == 5'd0;
		syscall <= f[19:15] == 5'd0;
		brk <= f[24:20] == 5'd0;
		eret <= f[28:25] == 4'd0;
		mtc0 <= f[31:29] == 3'd0;
		next_rand(v);
		pc <= {v[31:2], 2'b00};
		next_rand(v);
		alu_out <= v;
		next_rand(v);
		rt_data <= v;
	endtask

	task automatic predict_and_check();
		logic mis;
		logic ld_err;
		logic st_err;
		logic int_pend;
		logic exp_req;
		logic [3:0] lanes;
		logic [31:0] exp_wdata;
		logic [31:0] exp_rdata;
		case (mem_size)
			SIZE_HALF: mis = alu_out[0];
			SIZE_WORD: mis = alu_out[1:0] != 2'b00;
			default: mis = 1'b0;
		endcase
		ld_err = mem_req && !mem_wr && mis;
		st_err = mem_req && mem_wr && mis;
		// IE set, EXL clear, an enabled IP bit pending
		int_pend = m_status[0] && !m_status[1] && ((m_cause[15:8] & m_status[15:8]) != 8'd0);
		exp_take = 1'b1;
		exp_code = EXC_INT;
		if (int_pend && is_instr)
			exp_code = EXC_INT;
		else if (addr_err_if)
			exp_code = EXC_ADEL;
		else if (reserved_instr)
			exp_code = EXC_RI;
		else if (int_ovf)
			exp_code = EXC_OV;
		else if (syscall)
			exp_code = EXC_SYS;
		else if (brk)
			exp_code = EXC_BP;
		else if (ld_err)
			exp_code = EXC_ADEL;
		else if (st_err)
			exp_code = EXC_ADES;
		else
			exp_take = 1'b0;
		exp_req = mem_req && !mis && !exp_take;
		case (mem_size)
			SIZE_BYTE: begin
				exp_wdata = {4{rt_data[7:0]}};
				lanes = 4'b0001 << alu_out[1:0];
			end
			SIZE_HALF: begin
				exp_wdata = {2{rt_data[15:0]}};
				lanes = alu_out[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				exp_wdata = rt_data;
				lanes = 4'b1111;
			end
		endcase
		exp_rdata = 32'd0;
		if (cp0_sel == 3'd0) begin
			case (rd)
				CP0_BADVADDR: exp_rdata = m_badvaddr;
				CP0_COUNT: exp_rdata = m_count;
				CP0_STATUS: exp_rdata = m_status;
				CP0_CAUSE: exp_rdata = m_cause;
				CP0_EPC: exp_rdata = m_epc;
				default: exp_rdata = 32'd0;
			endcase
		end
		check_flag("data_req", exp_req, data_req);
		check_flag("data_wr", mem_wr, data_wr);
		check_size("data_size", mem_size, data_size);
		check_word("data_addr", alu_out, data_addr);
		check_word("data_wdata", exp_wdata, data_wdata);
		check_strb("data_wstrb", (exp_req && mem_wr) ? lanes : 4'b0000, data_wstrb);
		check_flag("exc_flush", exp_take || eret, exc_flush);
		if (exp_take || eret)
			check_word("exc_target", exp_take ? VECTOR : m_epc, exc_target);
		check_word("cp0_rdata", exp_rdata, cp0_rdata);
	endtask

	// applies the cycle that just ended to the model
	task automatic update_model();
		logic mtc0_w;
		mtc0_w = mtc0 && !exp_take && !eret && !stall && cp0_sel == 3'd0;
		if (mtc0_w && rd == CP0_COUNT)
			m_count = rt_data;
		else if (m_tick)
			m_count = m_count + 32'd1;
		m_tick = !m_tick;
		m_cause[15:10] = ext_int;
		if (!stall && exp_take) begin
			m_status[1] = 1'b1;
			m_cause[31] = in_delay_slot;
			m_cause[6:2] = exp_code;
			m_epc = in_delay_slot ? pc - 32'd4 : pc;
			if (exp_code == EXC_ADEL || exp_code == EXC_ADES)
				m_badvaddr = addr_err_if ? pc : alu_out;
		end else if (!stall && eret) begin
			m_status[1] = 1'b0;
		end else if (mtc0_w) begin
			// IM, EXL and IE only
			if (rd == CP0_STATUS)
				m_status = (m_status & ~32'h0000_FF03) | (rt_data & 32'h0000_FF03);
			else if (rd == CP0_CAUSE)
				m_cause[9:8] = rt_data[9:8];
			else if (rd == CP0_EPC)
				m_epc = rt_data;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		{ext_int, stall, is_instr, in_delay_slot, pc, alu_out, rt_data, rd, cp0_sel} = '0;
		{mem_req, mem_wr, addr_err_if, reserved_instr, int_ovf, syscall, brk, eret, mtc0} = '0;
		mem_size = SIZE_BYTE;
		// BEV only
		m_status = 32'h0040_0000;
		m_cause = 32'd0;
		m_epc = 32'd0;
		m_badvaddr = 32'd0;
		m_count = 32'd0;
		m_tick = 1'b0;
		repeat (9) @(posedge clk);
		@(negedge clk);
		// quiet outputs while held in reset
		check_flag("data_req", 1'b0, data_req);
		check_flag("exc_flush", 1'b0, exc_flush);
		check_strb("data_wstrb", 4'b0000, data_wstrb);
		@(posedge clk);
		rst_n <= 1'b1;
		drive_random();
		@(negedge clk);
		predict_and_check();
		for (int n = 1; n < NUM_INSTR; n++) begin
			@(posedge clk);
			update_model();
			drive_random();
			@(negedge clk);
			predict_and_check();
		end
		$display("errors: word %0d, flag %0d, strobe %0d, size %0d",
			word_errs, flag_errs, strb_errs, size_errs);
		if (word_errs + flag_errs + strb_errs + size_errs == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
